// ==== bench/bk_periph_asserts.sv ====
// Bound concurrent assertions on the APB response and audio sample ports
`default_nettype none
`include "bk_params.svh"

module bk_periph_asserts (
	input logic                   clk_sys,
	input logic                   rst_n,
	input logic                   psel,
	input logic                   penable,
	input logic                   pready,
	input logic                   pslverr,
	input logic [`BK_SAMPLE_W-1:0] audio_l,
	input logic [`BK_SAMPLE_W-1:0] audio_r
);

	timeunit 1ns;
	timeprecision 1ps;

	// Slave never inserts wait states
	pready_high: assert property (@(posedge clk_sys) disable iff (!rst_n) pready)
		else $error("pready dropped low");

	pslverr_access_only: assert property (
		@(posedge clk_sys) disable iff (!rst_n) pslverr |-> (psel && penable))
		else $error("pslverr raised outside the access phase");

	// Both mixer paths leave the six LSBs clear
	audio_low_bits_zero: assert property (
		@(posedge clk_sys) disable iff (!rst_n) (audio_l[5:0] == 6'd0) && (audio_r[5:0] == 6'd0))
		else $error("audio sample has nonzero low bits");

endmodule

bind bk_periph_top bk_periph_asserts bk_periph_asserts_inst (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.psel    (psel),
	.penable (penable),
	.pready  (pready),
	.pslverr (pslverr),
	.audio_l (audio_l),
	.audio_r (audio_r)
);

`default_nettype wire

// ==== bench/bk_periph_tb.sv ====
// Peripheral slice testbench with clock, reset, stimulus table, checks and watchdog
`default_nettype none
`include "bk_params.svh"

module bk_periph_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DLY  = 2;
	localparam int RST_CYCLES = 3;

	// Row operations
	localparam int OP_WR    = 0;
	localparam int OP_RD    = 1;
	localparam int OP_ERR   = 2;
	localparam int OP_AUD_L = 3;
	localparam int OP_AUD_R = 4;
	localparam int OP_MIX   = 5;
	localparam int OP_KEY   = 6;
	localparam int OP_MOUSE = 7;
	localparam int OP_JOY   = 8;
	localparam int OP_RAND  = 9;

	logic                       clk_sys = 1'b0;
	logic                       rst_n;
	logic [`BK_ADDR_W-1:0]      paddr;
	logic                       psel;
	logic                       penable;
	logic                       pwrite;
	logic [`BK_DATA_W-1:0]      pwdata;
	logic [1:0]                 pstrb;
	logic [`BK_DATA_W-1:0]      prdata;
	logic                       pready;
	logic                       pslverr;
	logic                       key_stop;
	logic                       key_down;
	logic [`BK_DATA_W-1:0]      joystick_0;
	logic [`BK_DATA_W-1:0]      joystick_1;
	logic [`BK_PS2_MOUSE_W-1:0] ps2_mouse;
	logic                       key_stop_irq;
	logic [`BK_SAMPLE_W-1:0]    audio_l;
	logic [`BK_SAMPLE_W-1:0]    audio_r;
	logic [1:0]                 audio_mix;

	// Stimulus table columns
	string       row_name[$];
	int          row_op[$];
	logic [15:0] row_addr[$];
	logic [31:0] row_data[$];
	logic [1:0]  row_strb[$];
	logic [15:0] row_exp[$];

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	bk_periph_top bk_periph_top_inst (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.paddr        (paddr),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.pwdata       (pwdata),
		.pstrb        (pstrb),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.key_stop     (key_stop),
		.key_down     (key_down),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.ps2_mouse    (ps2_mouse),
		.key_stop_irq (key_stop_irq),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.audio_mix    (audio_mix)
	);

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (exp !== act) begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			$display("Test failures found");
			$fatal(1, "stopping at first mismatch in %s", name);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic apb_write(input logic [15:0] addr, input logic [15:0] data,
		input logic [1:0] strb);
		@(posedge clk_sys);
		#DRIVE_DLY;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		pstrb   = strb;
		@(posedge clk_sys);
		#DRIVE_DLY;
		penable = 1'b1;
		// Write lands on this edge
		@(posedge clk_sys);
		#DRIVE_DLY;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [15:0] addr, output logic [15:0] data, output logic err);
		@(posedge clk_sys);
		#DRIVE_DLY;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge clk_sys);
		#DRIVE_DLY;
		penable = 1'b1;
		// Mid access phase
		@(negedge clk_sys);
		data = prdata;
		err  = pslverr;
		@(posedge clk_sys);
		#DRIVE_DLY;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// Random speaker level and Covox word checked against the channel formula
	task automatic covox_random(input string name);
		logic [2:0]  lvl;
		logic [15:0] word;
		int          exp_l;
		int          exp_r;
		lvl  = 3'($urandom);
		word = 16'($urandom);
		apb_write(`BK_SYSREG_ADDR, {9'd0, lvl[2], lvl[1], 2'b00, lvl[0], 2'b00}, 2'b01);
		apb_write(`BK_PORT_ADDR, word, 2'b11);
		wait_cycles(2);
		exp_l = (int'(word[7:0]) * 2 + int'(lvl) * 32) * 64;
		exp_r = (int'(word[15:8]) * 2 + int'(lvl) * 32) * 64;
		@(negedge clk_sys);
		check_value({name, "_l"}, exp_l[15:0], audio_l);
		check_value({name, "_r"}, exp_r[15:0], audio_r);
	endtask

	task automatic watchdog(input int cycles);
		repeat (cycles) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, the run did not finish", cycles);
		$display("Test failures found");
		$fatal(1, "watchdog timeout");
	endtask

	task automatic add_row(input string name, input int op, input logic [15:0] addr,
		input logic [31:0] data, input logic [1:0] strb, input logic [15:0] exp);
		row_name.push_back(name);
		row_op.push_back(op);
		row_addr.push_back(addr);
		row_data.push_back(data);
		row_strb.push_back(strb);
		row_exp.push_back(exp);
	endtask

	//////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////
	task automatic build_table();
		// Config register strobes and decode errors
		add_row("cfg_reset", OP_RD, `BK_CONFIG_ADDR, 32'h0, 2'b00, 16'h0000);
		add_row("cfg_hi_strb", OP_WR, `BK_CONFIG_ADDR, 32'hFFFF, 2'b10, 16'h0);
		add_row("cfg_hi_strb", OP_RD, `BK_CONFIG_ADDR, 32'h0, 2'b00, 16'h0000);
		add_row("cfg_mask", OP_WR, `BK_CONFIG_ADDR, 32'hFFFE, 2'b01, 16'h0);
		add_row("cfg_mask", OP_RD, `BK_CONFIG_ADDR, 32'h0, 2'b00, 16'h000E);
		add_row("cfg_mix3", OP_MIX, 16'h0, 32'h0, 2'b00, 16'h0003);
		add_row("cfg_mix1", OP_WR, `BK_CONFIG_ADDR, 32'h0004, 2'b11, 16'h0);
		add_row("cfg_mix1", OP_MIX, 16'h0, 32'h0, 2'b00, 16'h0001);
		add_row("cfg_mix1", OP_RD, `BK_CONFIG_ADDR, 32'h0, 2'b00, 16'h0004);
		add_row("bad_addr", OP_ERR, 16'o177710, 32'h0, 2'b00, 16'h0001);
		add_row("good_addr", OP_ERR, `BK_CONFIG_ADDR, 32'h0, 2'b00, 16'h0000);
		// Speaker through the sysreg with Covox off
		add_row("spk_low", OP_WR, `BK_SYSREG_ADDR, 32'h0064, 2'b01, 16'h0);
		add_row("spk_low", OP_AUD_L, 16'h0, 32'h0, 2'b00, 16'hE000);
		add_row("spk_low", OP_AUD_R, 16'h0, 32'h0, 2'b00, 16'hE000);
		add_row("spk_both", OP_WR, `BK_SYSREG_ADDR, 32'h0044, 2'b11, 16'h0);
		add_row("spk_both", OP_AUD_L, 16'h0, 32'h0, 2'b00, 16'hA000);
		add_row("spk_page", OP_WR, `BK_SYSREG_ADDR, 32'h0864, 2'b11, 16'h0);
		add_row("spk_page", OP_AUD_R, 16'h0, 32'h0, 2'b00, 16'hA000);
		add_row("spk_bk0010", OP_WR, `BK_CONFIG_ADDR, 32'h0006, 2'b01, 16'h0);
		add_row("spk_bk0010", OP_WR, `BK_SYSREG_ADDR, 32'h0064, 2'b01, 16'h0);
		add_row("spk_bk0010", OP_AUD_L, 16'h0, 32'h0, 2'b00, 16'hC000);
		add_row("spk_bk0010", OP_WR, `BK_CONFIG_ADDR, 32'h0004, 2'b01, 16'h0);
		// Stop key block and sysreg readback
		add_row("stop_irq", OP_KEY, 16'h0, 32'h1, 2'b00, 16'h0001);
		add_row("stop_block", OP_WR, `BK_SYSREG_ADDR, 32'h1000, 2'b10, 16'h0);
		add_row("stop_block", OP_KEY, 16'h0, 32'h1, 2'b00, 16'h0000);
		add_row("stop_page", OP_WR, `BK_SYSREG_ADDR, 32'h0800, 2'b10, 16'h0);
		add_row("stop_page", OP_KEY, 16'h0, 32'h1, 2'b00, 16'h0000);
		add_row("stop_unblock", OP_WR, `BK_SYSREG_ADDR, 32'h0000, 2'b10, 16'h0);
		add_row("stop_unblock", OP_KEY, 16'h0, 32'h1, 2'b00, 16'h0001);
		add_row("sys_rd_down", OP_KEY, 16'h0, 32'h3, 2'b00, 16'h0001);
		add_row("sys_rd_down", OP_RD, `BK_SYSREG_ADDR, 32'h0, 2'b00, 16'h8080);
		add_row("sys_rd_up", OP_KEY, 16'h0, 32'h0, 2'b00, 16'h0000);
		add_row("sys_rd_up", OP_RD, `BK_SYSREG_ADDR, 32'h0, 2'b00, 16'h80C0);
		// Covox latch and mix with the speaker level left at 6
		add_row("covox_on", OP_WR, `BK_CONFIG_ADDR, 32'h0005, 2'b01, 16'h0);
		add_row("covox_word", OP_WR, `BK_PORT_ADDR, 32'h1234, 2'b11, 16'h0);
		add_row("covox_word", OP_AUD_L, 16'h0, 32'h0, 2'b00, 16'h4A00);
		add_row("covox_word", OP_AUD_R, 16'h0, 32'h0, 2'b00, 16'h3900);
		add_row("covox_hi", OP_WR, `BK_PORT_ADDR, 32'hFF00, 2'b10, 16'h0);
		add_row("covox_hi", OP_AUD_L, 16'h0, 32'h0, 2'b00, 16'h4A00);
		add_row("covox_hi", OP_AUD_R, 16'h0, 32'h0, 2'b00, 16'hAF80);
		add_row("covox_rand0", OP_RAND, 16'h0, 32'h0, 2'b00, 16'h0);
		add_row("covox_rand1", OP_RAND, 16'h0, 32'h0, 2'b00, 16'h0);
		add_row("covox_rand2", OP_RAND, 16'h0, 32'h0, 2'b00, 16'h0);
		add_row("covox_rand3", OP_RAND, 16'h0, 32'h0, 2'b00, 16'h0);
		// Mouse directions and joystick override
		add_row("covox_off", OP_WR, `BK_CONFIG_ADDR, 32'h0004, 2'b01, 16'h0);
		add_row("port_idle", OP_RD, `BK_PORT_ADDR, 32'h0, 2'b00, 16'h0000);
		add_row("mouse_en", OP_WR, `BK_PORT_ADDR, 32'h0008, 2'b01, 16'h0);
		add_row("mouse_up", OP_MOUSE, 16'h0, 32'h0005_0101, 2'b00, 16'h0);
		add_row("mouse_up", OP_RD, `BK_PORT_ADDR, 32'h0, 2'b00, 16'h0021);
		add_row("mouse_left", OP_MOUSE, 16'h0, 32'h00FF_FB32, 2'b00, 16'h0);
		add_row("mouse_left", OP_RD, `BK_PORT_ADDR, 32'h0, 2'b00, 16'h0049);
		add_row("mouse_clear", OP_WR, `BK_PORT_ADDR, 32'h0000, 2'b01, 16'h0);
		add_row("mouse_clear", OP_RD, `BK_PORT_ADDR, 32'h0, 2'b00, 16'h0040);
		add_row("mouse_reen", OP_WR, `BK_PORT_ADDR, 32'h0008, 2'b01, 16'h0);
		add_row("mouse_edge", OP_MOUSE, 16'h0, 32'h00FD_0320, 2'b00, 16'h0);
		add_row("mouse_edge", OP_RD, `BK_PORT_ADDR, 32'h0, 2'b00, 16'h0000);
		add_row("mouse_diag", OP_MOUSE, 16'h0, 32'h00FC_0420, 2'b00, 16'h0);
		add_row("mouse_diag", OP_RD, `BK_PORT_ADDR, 32'h0, 2'b00, 16'h0006);
		add_row("joystick", OP_JOY, 16'h0, 32'h0002_0010, 2'b00, 16'h0);
		add_row("joystick", OP_RD, `BK_PORT_ADDR, 32'h0, 2'b00, 16'h0012);
		add_row("joy_release", OP_JOY, 16'h0, 32'h0, 2'b00, 16'h0);
		add_row("joy_release", OP_RD, `BK_PORT_ADDR, 32'h0, 2'b00, 16'h0000);
	endtask

	initial begin
		logic [15:0] rd_data;
		logic        rd_err;
		int          limit;
		void'($urandom(32'hc040_6161));
		rst_n      = 1'b0;
		paddr      = '0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		pwdata     = '0;
		pstrb      = 2'b00;
		key_stop   = 1'b0;
		key_down   = 1'b0;
		joystick_0 = '0;
		joystick_1 = '0;
		ps2_mouse  = '0;
		build_table();
		limit = row_op.size() * 10 + RST_CYCLES;
		fork
			watchdog(limit);
		join_none
		wait_cycles(RST_CYCLES);
		#DRIVE_DLY;
		rst_n = 1'b1;

		for (int i = 0; i < row_op.size(); i++) begin
			case (row_op[i])
				OP_WR: begin
					apb_write(row_addr[i], row_data[i][15:0], row_strb[i]);
					wait_cycles(2);
				end
				OP_RD: begin
					apb_read(row_addr[i], rd_data, rd_err);
					check_value(row_name[i], row_exp[i], rd_data);
				end
				OP_ERR: begin
					apb_read(row_addr[i], rd_data, rd_err);
					check_value(row_name[i], row_exp[i], {15'd0, rd_err});
				end
				OP_AUD_L: begin
					@(negedge clk_sys);
					check_value(row_name[i], row_exp[i], audio_l);
				end
				OP_AUD_R: begin
					@(negedge clk_sys);
					check_value(row_name[i], row_exp[i], audio_r);
				end
				OP_MIX: begin
					@(negedge clk_sys);
					check_value(row_name[i], row_exp[i], {14'd0, audio_mix});
				end
				OP_KEY: begin
					@(posedge clk_sys);
					#DRIVE_DLY;
					key_stop = row_data[i][0];
					key_down = row_data[i][1];
					wait_cycles(2);
					@(negedge clk_sys);
					check_value(row_name[i], row_exp[i], {15'd0, key_stop_irq});
				end
				OP_MOUSE: begin
					@(posedge clk_sys);
					#DRIVE_DLY;
					// New report is flagged by toggling bit 24
					ps2_mouse = {~ps2_mouse[24], row_data[i][23:0]};
					wait_cycles(2);
				end
				OP_JOY: begin
					@(posedge clk_sys);
					#DRIVE_DLY;
					joystick_0 = row_data[i][15:0];
					joystick_1 = row_data[i][31:16];
					wait_cycles(2);
				end
				default: covox_random(row_name[i]);
			endcase
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hdl
hdl/bk_bus_pkg.sv
hdl/bk_audio_pkg.sv
hdl/bk_config_regs.sv
hdl/bk_sysreg.sv
hdl/bk_mouse_port.sv
hdl/bk_audio_mixer.sv
hdl/bk_periph_top.sv
bench/bk_periph_asserts.sv
bench/bk_periph_tb.sv

// ==== hdl/bk_audio_mixer.sv ====
// Covox byte latch and left/right sample mixer
`default_nettype none
`include "bk_params.svh"

module bk_audio_mixer (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    covox_wr,
	input  logic [`BK_DATA_W-1:0]   wdata,
	input  logic [1:0]              strb,
	input  logic                    covox_en,
	input  bk_audio_pkg::spk_bits_t spk,
	output bk_audio_pkg::sample_t   audio_l,
	output bk_audio_pkg::sample_t   audio_r
);

	bk_audio_pkg::covox_byte_t cvx_l;
	bk_audio_pkg::covox_byte_t cvx_r;

	// One channel, sum sits above six zero LSBs
	function automatic bk_audio_pkg::sample_t mix_channel(
		input bk_audio_pkg::covox_byte_t cvx,
		input bk_audio_pkg::spk_bits_t   lvl,
		input logic                      cvx_sel
	);
		bk_audio_pkg::mix_sum_t sum;
		sum = {1'b0, cvx, 1'b0} + {2'b00, lvl, 5'b00000};
		if (cvx_sel)
			return {sum, 6'd0};
		return {lvl, 13'd0};
	endfunction

	// Low byte feeds the left channel, high byte the right
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cvx_l <= '0;
			cvx_r <= '0;
		end else if (covox_wr) begin
			if (strb[0])
				cvx_l <= wdata[7:0];
			if (strb[1])
				cvx_r <= wdata[15:8];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= mix_channel(cvx_l, spk, covox_en);
			audio_r <= mix_channel(cvx_r, spk, covox_en);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/bk_audio_pkg.sv ====
// Audio side types: speaker level, Covox byte, mixer sum and output sample
`default_nettype none
`include "bk_params.svh"

package bk_audio_pkg;

	// Three speaker bits form the one-bit-DAC level
	typedef logic [`BK_SPK_W-1:0] spk_bits_t;

	typedef logic [`BK_COVOX_W-1:0] covox_byte_t;

	// Covox byte doubled plus speaker, two bits of headroom
	typedef logic [`BK_COVOX_W+1:0] mix_sum_t;

	// Unsigned output sample
	typedef logic [`BK_SAMPLE_W-1:0] sample_t;

endpackage

`default_nettype wire

// ==== hdl/bk_bus_pkg.sv ====
// Bus side types: sysreg write word views and configuration register layout
`default_nettype none
`include "bk_params.svh"

package bk_bus_pkg;

	// Stereo mix setting, 0 none up to 3 full mono
	typedef logic [1:0] mix_t;

	// Control view of a sysreg write
	typedef struct packed {
		logic [2:0]  rsvd_hi;
		logic        stop_block;
		logic        page_flag;
		logic [10:0] rsvd_lo;
	} sysreg_ctrl_t;

	// Speaker view of the same word
	typedef struct packed {
		logic [8:0] rsvd_hi;
		logic       spk_hi;
		logic       spk_mid;
		logic [1:0] rsvd_mid;
		logic       spk_lo;
		logic [1:0] rsvd_lo;
	} sysreg_spk_t;

	typedef union packed {
		sysreg_ctrl_t ctrl;
		sysreg_spk_t  spk;
	} sysreg_word_u;

	// Configuration register, upper bits read as zero
	typedef struct packed {
		logic [`BK_DATA_W-5:0] rsvd;
		mix_t                  mix;
		logic                  bk0010;
		logic                  covox_en;
	} config_reg_t;

endpackage

`default_nettype wire

// ==== hdl/bk_config_regs.sv ====
// APB decode, configuration register, write strobes and read data mux
`default_nettype none
`include "bk_params.svh"

module bk_config_regs (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic [`BK_ADDR_W-1:0]    paddr,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  logic [`BK_DATA_W-1:0]    pwdata,
	input  logic [1:0]               pstrb,
	output logic [`BK_DATA_W-1:0]    prdata,
	output logic                     pready,
	output logic                     pslverr,
	input  logic [`BK_DATA_W-1:0]    sysreg_rdata,
	input  logic [`BK_DATA_W-1:0]    port_rdata,
	output logic                     sysreg_wr,
	output logic                     sysreg_access,
	output logic                     covox_wr,
	output logic                     mouse_wr,
	output bk_bus_pkg::sysreg_word_u wdata,
	output logic [1:0]               strb,
	output logic                     covox_en,
	output logic                     bk0010,
	output bk_bus_pkg::mix_t         audio_mix
);

	bk_bus_pkg::config_reg_t cfg;
	logic hit_sys;
	logic hit_port;
	logic hit_cfg;
	logic access_wr;

	assign hit_sys  = (paddr == `BK_SYSREG_ADDR);
	assign hit_port = (paddr == `BK_PORT_ADDR);
	assign hit_cfg  = (paddr == `BK_CONFIG_ADDR);

	// No wait states
	assign pready    = 1'b1;
	assign pslverr   = psel && penable && !(hit_sys || hit_port || hit_cfg);
	assign access_wr = psel && penable && pwrite;

	//////////////////////////////////////////////////
	// Strobes toward the register blocks
	//////////////////////////////////////////////////
	assign sysreg_wr     = access_wr && hit_sys;
	assign sysreg_access = psel && !penable && hit_sys;
	// Port write goes to Covox or to the mouse, never both
	assign covox_wr = access_wr && hit_port && cfg.covox_en;
	assign mouse_wr = access_wr && hit_port && !cfg.covox_en;
	assign wdata    = pwdata;
	assign strb     = pstrb;

	// High byte is all reserved, so only strobe 0 matters
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cfg <= `BK_CONFIG_RST;
		end else if (access_wr && hit_cfg && pstrb[0]) begin
			cfg.covox_en <= pwdata[0];
			cfg.bk0010   <= pwdata[1];
			cfg.mix      <= pwdata[3:2];
		end
	end

	assign covox_en  = cfg.covox_en;
	assign bk0010    = cfg.bk0010;
	assign audio_mix = cfg.mix;

	// Read data mux
	always_comb begin
		prdata = '0;
		if (psel) begin
			if (hit_cfg)
				prdata = cfg;
			else if (hit_sys)
				prdata = sysreg_rdata;
			else if (hit_port)
				prdata = port_rdata;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/bk_mouse_port.sv ====
// Parallel port input side: mouse direction latch and joystick or mouse select
`default_nettype none
`include "bk_params.svh"

module bk_mouse_port (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic                       mouse_wr,
	input  logic [`BK_DATA_W-1:0]      wdata,
	input  logic [1:0]                 strb,
	input  logic                       covox_en,
	input  logic [`BK_DATA_W-1:0]      joystick_0,
	input  logic [`BK_DATA_W-1:0]      joystick_1,
	input  logic [`BK_PS2_MOUSE_W-1:0] ps2_mouse,
	output logic [`BK_DATA_W-1:0]      port_rdata
);

	logic [`BK_DATA_W-1:0]  joy_or;
	logic [`BK_MOUSE_W-1:0] mouse_state;
	logic                   mouse_en;
	logic                   mouse_sel;
	logic                   pkt_flag_q;
	logic                   pkt_new;
	logic [8:0]             dx;
	logic [8:0]             dy;
	logic                   dx_pos;
	logic                   dx_neg;
	logic                   dy_pos;
	logic                   dy_neg;

	assign joy_or = joystick_0 | joystick_1;

	// Packet flag toggles once per mouse report
	assign pkt_new = (pkt_flag_q != ps2_mouse[24]);

	// Nine bit signed movement, sign bits sit in the PS/2 status byte
	assign dx = {ps2_mouse[4], ps2_mouse[15:8]};
	assign dy = {ps2_mouse[5], ps2_mouse[23:16]};

	assign dx_pos = !dx[8] && (dx > `BK_MOUSE_THRESH_POS);
	assign dx_neg = dx[8] && (~dx > `BK_MOUSE_THRESH_NEG);
	assign dy_pos = !dy[8] && (dy > `BK_MOUSE_THRESH_POS);
	assign dy_neg = dy[8] && (~dy > `BK_MOUSE_THRESH_NEG);

	//////////////////////////////////////////////////
	// Mouse state
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			mouse_state <= '0;
			mouse_en    <= 1'b0;
			mouse_sel   <= 1'b0;
			pkt_flag_q  <= 1'b0;
		end else begin
			pkt_flag_q <= ps2_mouse[24];
			if (|joy_or)
				mouse_sel <= 1'b0;
			// Clearing enable also drops the latched directions
			if (mouse_wr && strb[0]) begin
				mouse_en <= wdata[3];
				if (!wdata[3])
					mouse_state[3:0] <= '0;
			end
			if (pkt_new) begin
				mouse_state[6] <= ps2_mouse[1];
				mouse_state[5] <= ps2_mouse[0];
				mouse_sel      <= 1'b1;
				if (mouse_en) begin
					// Each axis latches once until software clears it
					if (!mouse_state[0] && !mouse_state[2]) begin
						if (dy_pos)
							mouse_state[0] <= 1'b1;
						if (dy_neg)
							mouse_state[2] <= 1'b1;
					end
					if (!mouse_state[1] && !mouse_state[3]) begin
						if (dx_pos)
							mouse_state[1] <= 1'b1;
						if (dx_neg)
							mouse_state[3] <= 1'b1;
					end
				end
			end
		end
	end

	assign port_rdata = (!covox_en && mouse_sel) ?
		{{(`BK_DATA_W - `BK_MOUSE_W){1'b0}}, mouse_state} : joy_or;

endmodule

`default_nettype wire

// ==== hdl/bk_params.svh ====
// Register addresses, field widths, reset values and mouse thresholds
`ifndef BK_PARAMS_SVH
`define BK_PARAMS_SVH

//////////////////////////////////////////////////
// Bus geometry
//////////////////////////////////////////////////
`define BK_ADDR_W 16
`define BK_DATA_W 16

// Register map, octal as on the real machine
`define BK_SYSREG_ADDR 16'o177716
`define BK_PORT_ADDR   16'o177714
`define BK_CONFIG_ADDR 16'o177712

// High byte of a sysreg read
`define BK_START_BYTE 8'h80

//////////////////////////////////////////////////
// Field widths and reset values
//////////////////////////////////////////////////
`define BK_SPK_W       3
`define BK_COVOX_W     8
`define BK_SAMPLE_W    16
`define BK_MOUSE_W     7
`define BK_PS2_MOUSE_W 25

`define BK_CONFIG_RST 16'h0000
`define BK_SPK_RST    3'b000

// Movement needed before a direction bit latches
`define BK_MOUSE_THRESH_POS 9'd3
`define BK_MOUSE_THRESH_NEG 9'd2

`endif

// ==== hdl/bk_periph_top.sv ====
// Peripheral register slice top: APB register block, sysreg, parallel port and mixer
`default_nettype none
`include "bk_params.svh"

module bk_periph_top (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic [`BK_ADDR_W-1:0]      paddr,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [`BK_DATA_W-1:0]      pwdata,
	input  logic [1:0]                 pstrb,
	output logic [`BK_DATA_W-1:0]      prdata,
	output logic                       pready,
	output logic                       pslverr,
	input  logic                       key_stop,
	input  logic                       key_down,
	input  logic [`BK_DATA_W-1:0]      joystick_0,
	input  logic [`BK_DATA_W-1:0]      joystick_1,
	input  logic [`BK_PS2_MOUSE_W-1:0] ps2_mouse,
	output logic                       key_stop_irq,
	output bk_audio_pkg::sample_t      audio_l,
	output bk_audio_pkg::sample_t      audio_r,
	output bk_bus_pkg::mix_t           audio_mix
);

	logic [`BK_DATA_W-1:0]    sysreg_rdata;
	logic [`BK_DATA_W-1:0]    port_rdata;
	logic                     sysreg_wr;
	logic                     sysreg_access;
	logic                     covox_wr;
	logic                     mouse_wr;
	bk_bus_pkg::sysreg_word_u wdata;
	logic [1:0]               strb;
	logic                     covox_en;
	logic                     bk0010;
	bk_audio_pkg::spk_bits_t  spk;

	//////////////////////////////////////////////////
	// Register block
	//////////////////////////////////////////////////
	bk_config_regs bk_config_regs_inst (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.paddr         (paddr),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.pwdata        (pwdata),
		.pstrb         (pstrb),
		.prdata        (prdata),
		.pready        (pready),
		.pslverr       (pslverr),
		.sysreg_rdata  (sysreg_rdata),
		.port_rdata    (port_rdata),
		.sysreg_wr     (sysreg_wr),
		.sysreg_access (sysreg_access),
		.covox_wr      (covox_wr),
		.mouse_wr      (mouse_wr),
		.wdata         (wdata),
		.strb          (strb),
		.covox_en      (covox_en),
		.bk0010        (bk0010),
		.audio_mix     (audio_mix)
	);

	bk_sysreg bk_sysreg_inst (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.sysreg_wr     (sysreg_wr),
		.sysreg_access (sysreg_access),
		.pwrite        (pwrite),
		.wdata         (wdata),
		.strb          (strb),
		.bk0010        (bk0010),
		.key_stop      (key_stop),
		.key_down      (key_down),
		.sysreg_rdata  (sysreg_rdata),
		.spk           (spk),
		.key_stop_irq  (key_stop_irq)
	);

	// Port input side
	bk_mouse_port bk_mouse_port_inst (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.mouse_wr   (mouse_wr),
		.wdata      (wdata),
		.strb       (strb),
		.covox_en   (covox_en),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.ps2_mouse  (ps2_mouse),
		.port_rdata (port_rdata)
	);

	bk_audio_mixer bk_audio_mixer_inst (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.covox_wr (covox_wr),
		.wdata    (wdata),
		.strb     (strb),
		.covox_en (covox_en),
		.spk      (spk),
		.audio_l  (audio_l),
		.audio_r  (audio_r)
	);

endmodule

`default_nettype wire

// ==== hdl/bk_sysreg.sv ====
// System register: speaker latch, stop key block and supervisor flag
`default_nettype none
`include "bk_params.svh"

module bk_sysreg (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     sysreg_wr,
	input  logic                     sysreg_access,
	input  logic                     pwrite,
	input  bk_bus_pkg::sysreg_word_u wdata,
	input  logic [1:0]               strb,
	input  logic                     bk0010,
	input  logic                     key_stop,
	input  logic                     key_down,
	output logic [`BK_DATA_W-1:0]    sysreg_rdata,
	output bk_audio_pkg::spk_bits_t  spk,
	output logic                     key_stop_irq
);

	logic stop_block;
	logic super_flg;

	// Bit 11 set on a high byte write selects a memory page, not the speaker
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			spk        <= `BK_SPK_RST;
			stop_block <= 1'b0;
		end else if (sysreg_wr) begin
			if (strb[0] && (!strb[1] || !wdata.ctrl.page_flag)) begin
				spk <= {wdata.spk.spk_hi, wdata.spk.spk_mid, wdata.spk.spk_lo && !bk0010};
			end
			if (strb[1] && !wdata.ctrl.page_flag)
				stop_block <= wdata.ctrl.stop_block;
		end
	end

	// Supervisor flag records the direction of the latest access
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			super_flg <= 1'b0;
		else if (sysreg_access)
			super_flg <= pwrite;
	end

	assign key_stop_irq = key_stop && !stop_block;

	assign sysreg_rdata = {`BK_START_BYTE, 1'b1, !key_down, 3'b000, super_flg, 2'b00};

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the peripheral slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f compile.f --top-module bk_periph_tb -o bk_periph_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/bk_periph_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qF 'All tests passed!'; then
	exit 0
fi
exit 1
